// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = enigmaTb
FILELIST  = sources.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the simulator's exit status is lost in the pipe, so the log decides
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: logic/enigmaCtrl.sv
// Input capture and control for the cipher engine.
// Turns load cycles into table writes and encrypt cycles into scrambler
// requests, each tagged with the rotor position it was sampled at.

module enigmaCtrl
    import enigmaPkg::*;
(
    input  logic      clk,
    input  logic      srst_n,
    input  logic      load,
    input  logic      encrypt,
    input  symbolT    codeIn,
    output tableWrT   tableWr,
    output lookupReqT req
);

    symbolT loadAddr;  // next table entry to fill
    symbolT rotorPos;  // position for the next encrypted symbol

    // ====================
    // capture and counters
    // ====================

    always_ff @(posedge clk) begin
        tableWr.addr <= loadAddr;
        tableWr.data <= codeIn;
        req.sym      <= codeIn;
        req.pos      <= rotorPos;  // position before this symbol steps it

        if (!srst_n) begin
            tableWr.en <= 1'b0;
            req.valid  <= 1'b0;
            loadAddr   <= '0;
            rotorPos   <= '0;
        end else begin
            tableWr.en <= load;
            req.valid  <= encrypt;

            // address restarts as soon as a load burst ends
            if (load) begin
                loadAddr <= loadAddr + 1'b1;
            end else begin
                loadAddr <= '0;
            end

            if (load) begin
                rotorPos <= '0;  // new table, rotor back home
            end else if (encrypt) begin
                rotorPos <= rotorPos + 1'b1;
            end
        end
    end

    // ====================
    // checks
    // ====================

    // the two qualifiers share codeIn, so only one may own a cycle
    loadEncryptExclusive: assert property (
        @(posedge clk) disable iff (!srst_n) !(load && encrypt)
    );

    // a symbol never enters the scrambler while the table is changing
    reqNoWrite: assert property (
        @(posedge clk) disable iff (!srst_n) req.valid |-> !tableWr.en
    );

endmodule

// File: logic/enigmaPkg.sv
// Shared types for the cipher engine.
// Modules take these through a wildcard import in their headers.

`include "enigma_macros.svh"

package enigmaPkg;

    typedef logic [`SYM_BITS-1:0] symbolT;

    // rotor table write, one entry per load cycle
    typedef struct packed {
        logic   en;
        symbolT addr;
        symbolT data;
    } tableWrT;

    // symbol entering the scrambler with its own rotor position
    typedef struct packed {
        logic   valid;
        symbolT sym;
        symbolT pos;
    } lookupReqT;

    // reflector output, position still attached for the return path
    typedef struct packed {
        logic   valid;
        symbolT sym;
        symbolT pos;
    } reflectedT;

endpackage

// File: logic/enigmaTop.sv
// Top level of the single-rotor cipher engine.
// Load a 64-entry permutation with load, then stream symbols with encrypt.
// Each result shows on codeOut two clocks after its input was sampled.

module enigmaTop
    import enigmaPkg::*;
(
    input  logic   clk,
    input  logic   srst_n,
    input  logic   load,
    input  logic   encrypt,
    input  symbolT codeIn,
    output symbolT codeOut,
    output logic   codeValid
);

    tableWrT   tableWr;
    lookupReqT req;
    reflectedT refl;
    symbolT    fwdIdx;
    symbolT    fwdVal;
    symbolT    invIdx;
    symbolT    invVal;

    // ====================
    // control
    // ====================

    enigmaCtrl enigmaCtrl_i (
        .clk     (clk),
        .srst_n  (srst_n),
        .load    (load),
        .encrypt (encrypt),
        .codeIn  (codeIn),
        .tableWr (tableWr),
        .req     (req)
    );

    rotorTable rotorTable_i (
        .clk     (clk),
        .tableWr (tableWr),
        .fwdIdx  (fwdIdx),
        .invIdx  (invIdx),
        .fwdVal  (fwdVal),
        .invVal  (invVal)
    );

    // ====================
    // scrambler pipeline
    // ====================

    reflectStage reflectStage_i (
        .clk    (clk),
        .srst_n (srst_n),
        .req    (req),
        .fwdVal (fwdVal),
        .fwdIdx (fwdIdx),
        .refl   (refl)
    );

    returnStage returnStage_i (
        .clk       (clk),
        .srst_n    (srst_n),
        .refl      (refl),
        .invVal    (invVal),
        .invIdx    (invIdx),
        .codeOut   (codeOut),
        .codeValid (codeValid)
    );

endmodule

// File: logic/enigma_macros.svh
// Symbol width and alphabet size for the cipher engine.
// Included by the package and by any RTL that sizes tables or reflects values.

`ifndef ENIGMA_MACROS_SVH
`define ENIGMA_MACROS_SVH

`define SYM_BITS 6   // one cipher symbol
`define NUM_SYMS 64  // alphabet size, also rotor depth

`endif

// File: logic/reflectStage.sv
// First scrambler stage.
// Offsets the symbol by the rotor position, looks it up forward and
// reflects the result before handing it on with its position.

`include "enigma_macros.svh"

module reflectStage
    import enigmaPkg::*;
(
    input  logic      clk,
    input  logic      srst_n,
    input  lookupReqT req,
    input  symbolT    fwdVal,
    output symbolT    fwdIdx,
    output reflectedT refl
);

    symbolT reflected;

    assign fwdIdx    = req.sym + req.pos;                      // wraps mod 64
    assign reflected = symbolT'(`NUM_SYMS - 1) - fwdVal;       // v -> 63 - v

    always_ff @(posedge clk) begin
        refl.sym <= reflected;
        refl.pos <= req.pos;
        if (!srst_n) begin
            refl.valid <= 1'b0;
        end else begin
            refl.valid <= req.valid;
        end
    end

endmodule

// File: logic/returnStage.sv
// Return path of the scrambler.
// Looks up the reflected symbol in the inverse table, removes the rotor
// offset and registers the cipher output.

module returnStage
    import enigmaPkg::*;
(
    input  logic      clk,
    input  logic      srst_n,
    input  reflectedT refl,
    input  symbolT    invVal,
    output symbolT    invIdx,
    output symbolT    codeOut,
    output logic      codeValid
);

    symbolT unshifted;

    assign invIdx    = refl.sym;
    assign unshifted = invVal - refl.pos;  // undo the forward offset, mod 64

    always_ff @(posedge clk) begin
        codeOut <= unshifted;
        if (!srst_n) begin
            codeValid <= 1'b0;
        end else begin
            codeValid <= refl.valid;
        end
    end

    // output qualifier comes out of reset quiet
    validLowAfterReset: assert property (
        @(posedge clk) !srst_n |=> !codeValid
    );

endmodule

// File: logic/rotorTable.sv
// Rotor storage with forward and inverse tables.
// Each write fills the forward entry and the matching inverse entry, so
// both lookups are plain combinational reads.

`include "enigma_macros.svh"

module rotorTable
    import enigmaPkg::*;
(
    input  logic    clk,
    input  tableWrT tableWr,
    input  symbolT  fwdIdx,
    input  symbolT  invIdx,
    output symbolT  fwdVal,
    output symbolT  invVal
);

    symbolT fwdTab [`NUM_SYMS];
    symbolT invTab [`NUM_SYMS];

    always_ff @(posedge clk) begin
        if (tableWr.en) begin
            fwdTab[tableWr.addr] <= tableWr.data;
            invTab[tableWr.data] <= tableWr.addr;  // inverse built on the fly
        end
    end

    assign fwdVal = fwdTab[fwdIdx];
    assign invVal = invTab[invIdx];

    // round trip through both tables lands on the address just written
    inverseMatches: assert property (
        @(posedge clk) tableWr.en |=>
            invTab[fwdTab[$past(tableWr.addr)]] == $past(tableWr.addr)
    );

endmodule

// File: sources.f
+incdir+logic
logic/enigmaPkg.sv
logic/enigmaCtrl.sv
logic/rotorTable.sv
logic/reflectStage.sv
logic/returnStage.sv
logic/enigmaTop.sv
verif/enigmaTb.sv

// File: verif/enigmaTb.sv
// Self-checking testbench for the single-rotor cipher engine.
// Loads random permutations, streams symbols and compares each output with
// a reference model, including a decrypt round trip and a table change.

`include "enigma_macros.svh"

module enigmaTb
    import enigmaPkg::*;
();

    localparam int PERIOD     = 8;
    localparam int LATENCY    = 2;   // edges from input sample to codeOut
    localparam int NUM_SINGLE = 24;
    localparam int STREAM_LEN = 200;
    localparam int MIX_LEN    = 60;
    localparam int RUN_CYCLES = 4 * (`NUM_SYMS + 2) + 5 * NUM_SINGLE
                              + 2 * STREAM_LEN + 2 * MIX_LEN + 100;

    logic   clk;
    logic   srst_n;
    logic   load;
    logic   encrypt;
    symbolT codeIn;
    symbolT codeOut;
    logic   codeValid;

    logic [31:0] lfsr;
    int     cycleCnt;
    int     errCount;
    int     checkCount;
    int     sentCount;
    symbolT workPerm [`NUM_SYMS];
    symbolT permA [`NUM_SYMS];
    symbolT permB [`NUM_SYMS];
    symbolT modelTab [`NUM_SYMS];  // table the model believes is loaded
    symbolT modelPos;
    symbolT expSym [$];
    int     expEdge [$];
    symbolT plain [$];
    symbolT cipherLog [$];         // every symbol seen on codeOut

    enigmaTop enigmaTop_i (
        .clk       (clk),
        .srst_n    (srst_n),
        .load      (load),
        .encrypt   (encrypt),
        .codeIn    (codeIn),
        .codeOut   (codeOut),
        .codeValid (codeValid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // ====================
    // random source and reference model
    // ====================

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // taps 32,22,2,1
        return {s[30:0], fb};
    endfunction

    task automatic randBits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // Fisher-Yates over the whole alphabet
    task automatic shufflePerm();
        int i;
        int j;
        symbolT t;
        for (i = 0; i < `NUM_SYMS; i++) workPerm[i] = symbolT'(i);
        for (i = `NUM_SYMS - 1; i > 0; i--) begin
            randBits(12, j);
            j = j % (i + 1);
            t = workPerm[i];
            workPerm[i] = workPerm[j];
            workPerm[j] = t;
        end
    endtask

    function automatic symbolT refCipher(input symbolT tab [`NUM_SYMS],
                                         input symbolT pos, input symbolT sym);
        symbolT idx;
        symbolT mirrored;
        symbolT back;
        int a;
        idx = sym + pos;
        mirrored = symbolT'(`NUM_SYMS - 1) - tab[idx];
        back = '0;
        for (a = 0; a < `NUM_SYMS; a++) begin
            if (tab[a] == mirrored) back = symbolT'(a);  // inverse by search
        end
        return back - pos;
    endfunction

    // ====================
    // stimulus
    // ====================

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            load = 1'b0;
            encrypt = 1'b0;
        end
    endtask

    task automatic loadTable(input symbolT tab [`NUM_SYMS]);
        int i;
        for (i = 0; i < `NUM_SYMS; i++) begin
            @(posedge clk);
            #1;
            encrypt = 1'b0;
            load = 1'b1;
            codeIn = tab[i];
        end
        idle(1);
        modelTab = tab;
        modelPos = '0;  // any load sends the rotor home
    endtask

    task automatic sendSymbol(input symbolT sym, input symbolT expected);
        @(posedge clk);
        #1;
        load = 1'b0;
        encrypt = 1'b1;
        codeIn = sym;
        expSym.push_back(expected);
        expEdge.push_back(cycleCnt + 1 + LATENCY);  // sampled at the next edge
        modelPos = modelPos + 1'b1;
        sentCount++;
    endtask

    task automatic encryptSym(input symbolT sym);
        sendSymbol(sym, refCipher(modelTab, modelPos, sym));
    endtask

    task automatic drain();
        idle(1);
        while (expSym.size() != 0) @(posedge clk);
    endtask

    // ====================
    // checker
    // ====================

    always @(negedge clk) begin
        if (srst_n && codeValid === 1'b1) begin
            if (expSym.size() == 0) begin
                $display("Unexpected output at time %0t: codeValid high with nothing pending",
                         $time);
                errCount++;
            end else begin
                checkCount++;
                if (codeOut !== expSym[0]) begin
                    $display("Error %0t: codeOut %0d, expected %0d",
                             $time, codeOut, expSym[0]);
                    errCount++;
                end
                if (cycleCnt != expEdge[0]) begin
                    $display("Error %0t: result at edge %0d, expected edge %0d",
                             $time, cycleCnt, expEdge[0]);
                    errCount++;
                end
                void'(expSym.pop_front());
                void'(expEdge.pop_front());
            end
            cipherLog.push_back(codeOut);
        end
    end

    initial begin
        #(2 * RUN_CYCLES * PERIOD);  // twice the expected run length
        $display("Timeout: run did not finish within %0d cycles", 2 * RUN_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int i;
        int r;
        int diffCount;
        symbolT cipher [$];
        symbolT oldCipher [$];
        load = 1'b0;
        encrypt = 1'b0;
        codeIn = '0;
        srst_n = 1'b0;
        lfsr = 32'h47;
        modelPos = '0;
        repeat (5) @(posedge clk);
        #1;
        srst_n = 1'b1;

        idle(8);  // output must stay quiet with nothing issued
        if (codeValid !== 1'b0) begin
            $display("Error %0t: codeValid is %b after reset", $time, codeValid);
            errCount++;
        end

        shufflePerm();
        permA = workPerm;
        shufflePerm();
        permB = workPerm;
        loadTable(permA);

        // single symbols with idle gaps
        for (i = 0; i < NUM_SINGLE; i++) begin
            randBits(6, r);
            encryptSym(symbolT'(r));
            randBits(2, r);
            idle(r + 1);
        end
        drain();

        // back-to-back stream from position 0
        loadTable(permA);
        plain.delete();
        cipherLog.delete();
        for (i = 0; i < STREAM_LEN; i++) begin
            randBits(6, r);
            plain.push_back(symbolT'(r));
            encryptSym(symbolT'(r));
        end
        drain();

        // round trip, ciphertext back in from the same start
        cipher = cipherLog;
        if (cipher.size() != STREAM_LEN) begin
            $display("Captured %0d cipher symbols instead of %0d", cipher.size(), STREAM_LEN);
            errCount++;
        end
        loadTable(permA);
        for (i = 0; i < cipher.size(); i++) sendSymbol(cipher[i], plain[i]);
        drain();

        // switch to the second table partway through
        for (i = 0; i < MIX_LEN / 2; i++) begin
            randBits(6, r);
            encryptSym(symbolT'(r));
        end
        drain();
        loadTable(permB);
        cipherLog.delete();
        oldCipher.delete();
        for (i = 0; i < MIX_LEN; i++) begin
            randBits(6, r);
            oldCipher.push_back(refCipher(permA, modelPos, symbolT'(r)));
            encryptSym(symbolT'(r));
        end
        drain();

        // the DUT's own results must move away from the old table
        diffCount = 0;
        for (i = 0; i < cipherLog.size() && i < oldCipher.size(); i++) begin
            if (cipherLog[i] != oldCipher[i]) diffCount++;
        end
        if (diffCount == 0) begin
            $display("The new table gave the same results as the old one");
            errCount++;
        end

        idle(4);
        if (checkCount != sentCount) begin
            $display("Sent %0d symbols but checked %0d results", sentCount, checkCount);
            errCount++;
        end
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
